// File: design/adc_pkg.sv
// register map, version word, buffer sizing, PN9 helpers and the sample type

package adc_pkg;

  localparam int ADC_DATA_W = 16;
  localparam int UP_ADDR_W  = 14;

  // sample buffer
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  localparam logic [31:0] CORE_VERSION = 32'h0001_0061;

  // word addresses on the register bus
  localparam logic [UP_ADDR_W-1:0] REG_VERSION = 14'h000;
  localparam logic [UP_ADDR_W-1:0] REG_SCRATCH = 14'h001;
  localparam logic [UP_ADDR_W-1:0] REG_CNTRL   = 14'h010;
  localparam logic [UP_ADDR_W-1:0] REG_STATUS  = 14'h011;
  localparam logic [UP_ADDR_W-1:0] REG_SCOUNT  = 14'h012;

  // pn monitor
  localparam int PN_OOS_COUNT = 4;
  localparam int PN_CNT_W     = $clog2(PN_OOS_COUNT);
  localparam logic [ADC_DATA_W-1:0] PN9_SEED = 16'h92c1;

  typedef struct packed {
    logic [ADC_DATA_W-1:0] data;
    logic                  over_range;
  } adc_sample_t;

  // next 16-bit window of the x^9 + x^5 + 1 sequence, msb is the oldest bit
  function automatic logic [ADC_DATA_W-1:0] pn9_next(input logic [ADC_DATA_W-1:0] din);
    logic [2*ADC_DATA_W-1:0] seq;
    seq = {din, {ADC_DATA_W{1'b0}}};
    for (int i = ADC_DATA_W - 1; i >= 0; i--) begin
      seq[i] = seq[i+9] ^ seq[i+5];
    end
    return seq[ADC_DATA_W-1:0];
  endfunction

endpackage

// File: design/up_bus_if.sv
// internal processor register bus with master and slave modports
`timescale 1ns/10ps

interface up_bus_if;

  // write side
  logic                          up_wreq;
  logic [adc_pkg::UP_ADDR_W-1:0] up_waddr;
  logic [31:0]                   up_wdata;
  logic                          up_wack;

  // read side
  logic                          up_rreq;
  logic [adc_pkg::UP_ADDR_W-1:0] up_raddr;
  logic [31:0]                   up_rdata;
  logic                          up_rack;

  modport master (
    output up_wreq, up_waddr, up_wdata, up_rreq, up_raddr,
    input  up_wack, up_rdata, up_rack
  );

  modport slave (
    input  up_wreq, up_waddr, up_wdata, up_rreq, up_raddr,
    output up_wack, up_rdata, up_rack
  );

endinterface

// File: design/up_axi_lite.sv
// AXI-lite slave bridge that issues single-cycle register bus requests
`timescale 1ns/10ps

module up_axi_lite (
  input  logic        up_clk,
  input  logic        up_rstn,
  input  logic        awvalid,
  input  logic [15:0] awaddr,
  output logic        awready,
  input  logic        wvalid,
  input  logic [31:0] wdata,
  output logic        wready,
  output logic        bvalid,
  output logic [ 1:0] bresp,
  input  logic        bready,
  input  logic        arvalid,
  input  logic [15:0] araddr,
  output logic        arready,
  output logic        rvalid,
  output logic [ 1:0] rresp,
  output logic [31:0] rdata,
  input  logic        rready,
  up_bus_if.master    up
);

  typedef enum logic {ST_IDLE = 1'b0, ST_BUSY = 1'b1} axi_state_t;

  axi_state_t wr_state;
  axi_state_t rd_state;

  assign bresp = 2'b00;
  assign rresp = 2'b00;

  // **************************************************
  // write channel

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      wr_state   <= ST_IDLE;
      awready    <= 1'b0;
      wready     <= 1'b0;
      bvalid     <= 1'b0;
      up.up_wreq <= 1'b0;
    end else begin
      awready    <= 1'b0;
      wready     <= 1'b0;
      // request goes out the cycle after the handshake
      up.up_wreq <= awready;
      case (wr_state)
        ST_IDLE: begin
          if (awvalid && wvalid) begin
            awready  <= 1'b1;
            wready   <= 1'b1;
            wr_state <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          if (up.up_wack) begin
            bvalid <= 1'b1;
          end
          if (bvalid && bready) begin
            bvalid   <= 1'b0;
            wr_state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // byte address to word address
  always_ff @(posedge up_clk) begin
    if (wr_state == ST_IDLE && awvalid && wvalid) begin
      up.up_waddr <= awaddr[15:2];
      up.up_wdata <= wdata;
    end
  end

  // **************************************************
  // read channel

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      rd_state   <= ST_IDLE;
      arready    <= 1'b0;
      rvalid     <= 1'b0;
      up.up_rreq <= 1'b0;
    end else begin
      arready    <= 1'b0;
      up.up_rreq <= arready;
      case (rd_state)
        ST_IDLE: begin
          if (arvalid) begin
            arready  <= 1'b1;
            rd_state <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          if (up.up_rack) begin
            rvalid <= 1'b1;
          end
          if (rvalid && rready) begin
            rvalid   <= 1'b0;
            rd_state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge up_clk) begin
    if (rd_state == ST_IDLE && arvalid) begin
      up.up_raddr <= araddr[15:2];
    end
    // held until the master takes it
    if (up.up_rack) begin
      rdata <= up.up_rdata;
    end
  end

endmodule

// File: design/adc_capture.sv
// converter bus capture register producing sample structs
`timescale 1ns/10ps

module adc_capture (
  input  logic                        up_clk,
  input  logic                        up_rstn,
  input  logic                        adc_valid_in,
  input  logic [adc_pkg::ADC_DATA_W-1:0] adc_data_in,
  input  logic                        adc_or_in,
  output logic                        push,
  output adc_pkg::adc_sample_t        push_sample
);

  // single flop stage between the pins and the buffer

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      push <= 1'b0;
    end else begin
      push <= adc_valid_in;
    end
  end

  // data and over-range are captured every cycle
  always_ff @(posedge up_clk) begin
    push_sample.data       <= adc_data_in;
    push_sample.over_range <= adc_or_in;
  end

endmodule

// File: design/sample_fifo.sv
// first-word-fall-through sample buffer with overflow pulse
`timescale 1ns/10ps

module sample_fifo #(
  parameter type payload_t = adc_pkg::adc_sample_t
) (
  input  logic     up_clk,
  input  logic     up_rstn,
  input  logic     push,
  input  payload_t push_sample,
  input  logic     pop,
  output logic     pop_valid,
  output payload_t pop_sample,
  output logic     ovf
);

  payload_t                       mem [adc_pkg::FIFO_DEPTH];
  logic [adc_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [adc_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [adc_pkg::FIFO_CNT_W-1:0] count;
  logic                           full;
  logic                           wr_en;
  logic                           rd_en;

  assign full       = (count == adc_pkg::FIFO_DEPTH);
  assign pop_valid  = (count != '0);
  assign pop_sample = mem[rd_ptr];
  assign rd_en      = pop && pop_valid;
  // a pop in the same cycle frees a slot of a full buffer
  assign wr_en      = push && (!full || rd_en);

  always_ff @(posedge up_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_sample;
    end
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      ovf    <= 1'b0;
    end else begin
      // one pulse per dropped sample
      ovf <= push && !wr_en;
      if (wr_en) begin
        wr_ptr <= (wr_ptr == adc_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == adc_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: design/adc_channel.sv
// channel with data format, PN9 monitor, sample counter and register file
`timescale 1ns/10ps

module adc_channel (
  input  logic                           up_clk,
  input  logic                           up_rstn,
  input  logic                           pop_valid,
  input  adc_pkg::adc_sample_t           pop_sample,
  input  logic                           ovf,
  input  logic                           adc_dready,
  output logic                           pop,
  output logic                           adc_valid,
  output logic                           adc_enable,
  output logic [adc_pkg::ADC_DATA_W-1:0] adc_data,
  up_bus_if.slave                        up
);

  logic                           enable;
  logic                           dfmt_en;
  logic [31:0]                    scratch;
  logic [31:0]                    scount;
  logic                           pn_err;
  logic                           pn_oos;
  logic                           or_seen;
  logic                           ovf_seen;
  logic                           status_wr;
  logic                           deliver;
  logic                           pn_match;
  logic [adc_pkg::ADC_DATA_W-1:0] pn_pred;
  logic [adc_pkg::PN_CNT_W-1:0]   pn_cnt;

  // a disabled channel drains the buffer
  assign pop        = pop_valid && (!enable || adc_dready);
  assign deliver    = pop && enable;
  assign adc_enable = enable;
  assign pn_match   = (pop_sample.data == pn_pred);
  assign status_wr  = up.up_wreq && (up.up_waddr == adc_pkg::REG_STATUS);

  // **************************************************
  // output path

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      adc_valid <= 1'b0;
    end else begin
      adc_valid <= deliver;
    end
  end

  // msb flip turns offset binary into two's complement
  always_ff @(posedge up_clk) begin
    if (deliver) begin
      adc_data <= {pop_sample.data[adc_pkg::ADC_DATA_W-1] ^ dfmt_en,
                   pop_sample.data[adc_pkg::ADC_DATA_W-2:0]};
    end
  end

  // **************************************************
  // pn monitor

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      pn_pred <= adc_pkg::PN9_SEED;
      pn_cnt  <= '0;
      pn_oos  <= 1'b0;
    end else if (pop) begin
      // predictor free-runs while in sync and reseeds from data otherwise
      pn_pred <= adc_pkg::pn9_next(pn_oos ? pop_sample.data : pn_pred);
      // count runs that point toward the other state
      if (pn_match == pn_oos) begin
        if (pn_cnt == adc_pkg::PN_OOS_COUNT - 1) begin
          pn_oos <= !pn_oos;
          pn_cnt <= '0;
        end else begin
          pn_cnt <= pn_cnt + 1'b1;
        end
      end else begin
        pn_cnt <= '0;
      end
    end
  end

  // sticky status, a new event wins over a clear
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      pn_err   <= 1'b0;
      or_seen  <= 1'b0;
      ovf_seen <= 1'b0;
      scount   <= 32'd0;
    end else begin
      pn_err   <= (pn_err & ~(status_wr & up.up_wdata[0])) | (pop & ~pn_match & ~pn_oos);
      or_seen  <= (or_seen & ~(status_wr & up.up_wdata[2])) | (pop & pop_sample.over_range);
      ovf_seen <= (ovf_seen & ~(status_wr & up.up_wdata[3])) | ovf;
      if (deliver) begin
        scount <= scount + 32'd1;
      end
    end
  end

  // **************************************************
  // register access

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up.up_wack <= 1'b0;
      up.up_rack <= 1'b0;
      scratch    <= 32'd0;
      enable     <= 1'b0;
      dfmt_en    <= 1'b0;
    end else begin
      up.up_wack <= up.up_wreq;
      up.up_rack <= up.up_rreq;
      if (up.up_wreq && up.up_waddr == adc_pkg::REG_SCRATCH) begin
        scratch <= up.up_wdata;
      end
      if (up.up_wreq && up.up_waddr == adc_pkg::REG_CNTRL) begin
        enable  <= up.up_wdata[0];
        dfmt_en <= up.up_wdata[1];
      end
    end
  end

  // unmapped reads return zero
  always_ff @(posedge up_clk) begin
    if (up.up_rreq) begin
      case (up.up_raddr)
        adc_pkg::REG_VERSION: up.up_rdata <= adc_pkg::CORE_VERSION;
        adc_pkg::REG_SCRATCH: up.up_rdata <= scratch;
        adc_pkg::REG_CNTRL:   up.up_rdata <= {30'd0, dfmt_en, enable};
        adc_pkg::REG_STATUS:  up.up_rdata <= {28'd0, ovf_seen, or_seen, pn_oos, pn_err};
        adc_pkg::REG_SCOUNT:  up.up_rdata <= scount;
        default:              up.up_rdata <= 32'd0;
      endcase
    end
  end

endmodule

// File: design/axi_adc_core.sv
// top level of the capture core with AXI-lite control port
`timescale 1ns/10ps

module axi_adc_core (
  input  logic                           up_clk,
  input  logic                           up_rstn,

  // converter interface
  input  logic                           adc_valid_in,
  input  logic [adc_pkg::ADC_DATA_W-1:0] adc_data_in,
  input  logic                           adc_or_in,

  // dma interface
  input  logic                           adc_dready,
  output logic                           adc_valid,
  output logic                           adc_enable,
  output logic [adc_pkg::ADC_DATA_W-1:0] adc_data,

  // axi interface
  input  logic                           s_axi_awvalid,
  input  logic [15:0]                    s_axi_awaddr,
  output logic                           s_axi_awready,
  input  logic                           s_axi_wvalid,
  input  logic [31:0]                    s_axi_wdata,
  output logic                           s_axi_wready,
  output logic                           s_axi_bvalid,
  output logic [ 1:0]                    s_axi_bresp,
  input  logic                           s_axi_bready,
  input  logic                           s_axi_arvalid,
  input  logic [15:0]                    s_axi_araddr,
  output logic                           s_axi_arready,
  output logic                           s_axi_rvalid,
  output logic [ 1:0]                    s_axi_rresp,
  output logic [31:0]                    s_axi_rdata,
  input  logic                           s_axi_rready
);

  // sample stream
  logic                 push;
  adc_pkg::adc_sample_t push_sample;
  logic                 pop_valid;
  adc_pkg::adc_sample_t pop_sample;
  logic                 pop;
  logic                 ovf;

  up_bus_if up_bus ();

  up_axi_lite i_up_axi_lite (
    .up_clk  (up_clk),
    .up_rstn (up_rstn),
    .awvalid (s_axi_awvalid),
    .awaddr  (s_axi_awaddr),
    .awready (s_axi_awready),
    .wvalid  (s_axi_wvalid),
    .wdata   (s_axi_wdata),
    .wready  (s_axi_wready),
    .bvalid  (s_axi_bvalid),
    .bresp   (s_axi_bresp),
    .bready  (s_axi_bready),
    .arvalid (s_axi_arvalid),
    .araddr  (s_axi_araddr),
    .arready (s_axi_arready),
    .rvalid  (s_axi_rvalid),
    .rresp   (s_axi_rresp),
    .rdata   (s_axi_rdata),
    .rready  (s_axi_rready),
    .up      (up_bus));

  adc_capture i_capture (.*);

  sample_fifo #(.payload_t (adc_pkg::adc_sample_t)) i_fifo (.*);

  adc_channel i_channel (
    .up (up_bus),
    .*);

endmodule

// File: sim/axi_adc_core_properties.sv
// bound assertions on the register bus acks, AXI response hold and buffer pops
`timescale 1ns/10ps

module axi_adc_core_properties (
  input logic up_clk,
  input logic up_rstn,
  input logic wreq,
  input logic wack,
  input logic rreq,
  input logic rack,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready,
  input logic pop,
  input logic pop_valid
);

  // acks come exactly one cycle after their request
  ack_follows_wreq: assert property (@(posedge up_clk) disable iff (!up_rstn)
    wreq |=> wack) else $error("write ack missing after request");
  ack_follows_rreq: assert property (@(posedge up_clk) disable iff (!up_rstn)
    rreq |=> rack) else $error("read ack missing after request");

  // responses stay up until the master takes them
  bvalid_held: assert property (@(posedge up_clk) disable iff (!up_rstn)
    bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");
  rvalid_held: assert property (@(posedge up_clk) disable iff (!up_rstn)
    rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

  pop_needs_valid: assert property (@(posedge up_clk) disable iff (!up_rstn)
    pop |-> pop_valid) else $error("pop with an empty buffer");

endmodule

// one instance sees the bridge, the register bus and the channel pop together
bind axi_adc_core axi_adc_core_properties core_props (
  .up_clk    (up_clk),
  .up_rstn   (up_rstn),
  .wreq      (up_bus.up_wreq),
  .wack      (up_bus.up_wack),
  .rreq      (up_bus.up_rreq),
  .rack      (up_bus.up_rack),
  .bvalid    (s_axi_bvalid),
  .bready    (s_axi_bready),
  .rvalid    (s_axi_rvalid),
  .rready    (s_axi_rready),
  .pop       (pop),
  .pop_valid (pop_valid)
);

// File: sim/axi_adc_core_tb.sv
// testbench with clock, stim reader, AXI-lite bus tasks, value check and output scoreboard
`timescale 1ns/10ps

module axi_adc_core_tb;

  logic        up_clk;
  logic        up_rstn;
  logic        adc_valid_in;
  logic [15:0] adc_data_in;
  logic        adc_or_in;
  logic        adc_dready;
  logic        adc_valid;
  logic        adc_enable;
  logic [15:0] adc_data;
  logic        s_axi_awvalid;
  logic [15:0] s_axi_awaddr;
  logic        s_axi_awready;
  logic        s_axi_wvalid;
  logic [31:0] s_axi_wdata;
  logic        s_axi_wready;
  logic        s_axi_bvalid;
  logic [ 1:0] s_axi_bresp;
  logic        s_axi_bready;
  logic        s_axi_arvalid;
  logic [15:0] s_axi_araddr;
  logic        s_axi_arready;
  logic        s_axi_rvalid;
  logic [ 1:0] s_axi_rresp;
  logic [31:0] s_axi_rdata;
  logic        s_axi_rready;

  logic [15:0] expected_q[$];
  logic [15:0] pn_word = 16'h92c1;
  logic [15:0] lfsr = 16'd18430;
  int          hold_cycles = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          errors_before_test = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  axi_adc_core axi_adc_core_inst (.*);

  initial begin
    up_clk = 1'b0;
    forever #50 up_clk = ~up_clk;
  end

  function automatic logic [15:0] next_pn_word(input logic [15:0] w);
    logic [15:0] h;
    h = w;
    // x^9 + x^5 + 1, bit 0 is the newest
    for (int i = 0; i < 16; i++) begin
      h = {h[14:0], h[8] ^ h[4]};
    end
    return h;
  endfunction

  // galois lfsr, one step per bit
  function logic next_dready_bit();
    logic out;
    out  = lfsr[0];
    lfsr = (lfsr >> 1) ^ (out ? 16'hb400 : 16'h0000);
    return out;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
      errors++;
    end
  endtask

  // ************************************************
  // sample path

  always @(negedge up_clk) begin
    if (hold_cycles > 0) begin
      adc_dready = 1'b0;
      hold_cycles--;
    end else if (up_rstn) begin
      adc_dready = next_dready_bit();
    end
  end

  always @(negedge up_clk) begin
    if (up_rstn && adc_valid) begin
      if (expected_q.size() == 0) begin
        $display("adc_valid rose with no sample expected, data %h", adc_data);
        errors++;
      end else begin
        check_value("adc_data", adc_data, expected_q.pop_front());
      end
    end
  end

  always @(posedge up_clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  task automatic drive_sample(input logic [15:0] data, input logic over_range);
    @(negedge up_clk);
    adc_valid_in = 1'b1;
    adc_data_in  = data;
    adc_or_in    = over_range;
  endtask

  task automatic drive_pn(input int count, input logic corrupt);
    for (int i = 0; i < count; i++) begin
      drive_sample(pn_word ^ {15'd0, corrupt}, 1'b0);
      pn_word = next_pn_word(pn_word);
    end
  endtask

  // end a sample run and let the buffer catch up
  task automatic settle();
    @(negedge up_clk);
    adc_valid_in = 1'b0;
    repeat (3) @(negedge up_clk);
  endtask

  // ************************************************
  // AXI-lite master

  task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
    settle();
    while (expected_q.size() != 0) @(negedge up_clk);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    s_axi_bready  = 1'b1;
    do @(negedge up_clk); while (!s_axi_awready);
    check_value("wready", s_axi_wready, 32'd1);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    while (!s_axi_bvalid) @(negedge up_clk);
    check_value("bresp", s_axi_bresp, 32'd0);
    // control bit 0 drives the enable output
    if (addr == 16'h0040) begin
      check_value("adc_enable", adc_enable, {31'd0, data[0]});
    end
    @(negedge up_clk);
    s_axi_bready = 1'b0;
  endtask

  task automatic bus_read(input logic [15:0] addr, input logic [31:0] expected,
                          input logic [31:0] mask);
    settle();
    while (expected_q.size() != 0) @(negedge up_clk);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    s_axi_rready  = 1'b1;
    do @(negedge up_clk); while (!s_axi_arready);
    s_axi_arvalid = 1'b0;
    while (!s_axi_rvalid) @(negedge up_clk);
    check_value("rresp", s_axi_rresp, 32'd0);
    check_value($sformatf("rdata[%h]", addr), s_axi_rdata & mask, expected & mask);
    @(negedge up_clk);
    s_axi_rready = 1'b0;
  endtask

  task automatic finish_test(input string name);
    settle();
    while (expected_q.size() != 0) @(negedge up_clk);
    // room for a stray output to show up
    repeat (8) @(negedge up_clk);
    tests++;
    $display("test %s finished, %0d errors", name, errors - errors_before_test);
    errors_before_test = errors;
  endtask

  task automatic run_command(input string line);
    byte         cmd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    string       name;
    int          n;
    n = $sscanf(line, "%c %h %h %h", cmd, a, b, c);
    case (cmd)
      "W": bus_write(a[15:0], b);
      "R": bus_read(a[15:0], b, c);
      "S": drive_sample(a[15:0], b[0]);
      "P": drive_pn(a, 1'b0);
      "C": drive_pn(a, 1'b1);
      "B": hold_cycles = a;
      "E": expected_q.push_back(a[15:0]);
      "T": begin
        n = $sscanf(line, "%c %s", cmd, name);
        finish_test(name);
      end
      default: begin
        $display("unknown command in stim line: %s", line);
        errors++;
      end
    endcase
  endtask

  initial begin
    int    fd;
    string line;
    string lines[$];
    up_rstn       = 1'b0;
    adc_valid_in  = 1'b0;
    adc_data_in   = 16'd0;
    adc_or_in     = 1'b0;
    adc_dready    = 1'b0;
    s_axi_awvalid = 1'b0;
    s_axi_awaddr  = 16'd0;
    s_axi_wvalid  = 1'b0;
    s_axi_wdata   = 32'd0;
    s_axi_bready  = 1'b0;
    s_axi_arvalid = 1'b0;
    s_axi_araddr  = 16'd0;
    s_axi_rready  = 1'b0;
    fd = $fopen("sim/axi_adc_core_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stim file");
      $display("Errors found");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) && line.len() > 1 && line[0] != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
      cycle_limit = 40 * lines.size() + 200;
      repeat (16) @(negedge up_clk);
      up_rstn = 1'b1;
      foreach (lines[i]) begin
        run_command(lines[i]);
      end
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
      $finish;
    end
  end

endmodule

// File: sim/axi_adc_core_stim.txt
# W byte_addr data | R byte_addr expected mask | S data over_range | P count | C count
# B cycles | E expected_output | T test_name   (all numbers in hex, C = corrupted PN9)
R 0000 00010061 ffffffff
W 0004 a5a55a5a
R 0004 a5a55a5a ffffffff
R 0100 00000000 ffffffff
T registers
W 0040 1
S 1234 0
S 8001 0
S 00ff 0
E 1234
E 8001
E 00ff
W 0040 3
S 1234 0
S 8001 0
S 00ff 0
E 9234
E 0001
E 80ff
R 0048 00000006 ffffffff
T data_format
W 0040 0
S 4444 0
S 5555 0
S 6666 0
R 0048 00000006 ffffffff
R 0040 00000000 ffffffff
T disabled
P 10
W 0044 1
R 0044 00000000 00000003
C 1
P 4
R 0044 00000001 00000003
W 0044 1
R 0044 00000000 00000003
C 4
R 0044 00000003 00000003
P 4
R 0044 00000001 00000003
W 0044 1
R 0044 00000000 00000003
T pn_monitor
W 0044 f
W 0040 1
B 28
S 0100 0
S 0201 1
S 0302 0
S 0403 0
S 0504 0
S 0605 0
S 0706 0
S 0807 0
S 0908 0
S 0a09 0
E 0100
E 0201
E 0302
E 0403
E 0504
E 0605
E 0706
E 0807
R 0044 0000000c 0000000c
W 0044 c
R 0044 00000000 0000000c
T overflow

// File: sources.f
design/adc_pkg.sv
design/up_bus_if.sv
design/up_axi_lite.sv
design/adc_capture.sv
design/sample_fifo.sv
design/adc_channel.sv
design/axi_adc_core.sv
sim/axi_adc_core_properties.sv
sim/axi_adc_core_tb.sv

// File: Bender.yml
package:
  name: axi_adc_core

sources:
  - design/adc_pkg.sv
  - design/up_bus_if.sv
  - design/up_axi_lite.sv
  - design/adc_capture.sv
  - design/sample_fifo.sv
  - design/adc_channel.sv
  - design/axi_adc_core.sv
  - target: simulation
    files:
      - sim/axi_adc_core_properties.sv
      - sim/axi_adc_core_tb.sv
